//--- Makefile
SIM      = verilator
TOP      = cpuTb
FLIST    = flist.f
FLAGS    = --binary --timing --assert -j 0
RUNFLAGS = +verilator+error+limit+100
BUILDDIR = obj_dir
BIN      = $(BUILDDIR)/V$(TOP)
LOG      = sim.log
FAILMSG  = Test failed
PASSMSG  = Test completed successfully
SOURCES  = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILDDIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG) || ! grep -q "$(PASSMSG)" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- flist.f
verilog/cpuPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/controlMain.sv
verilog/hazardUnit.sv
verilog/pipelineCore.sv
verilog/instrMem.sv
verilog/dataMem.sv
verilog/cpuTop.sv
tb/cpuTop_properties.sv
tb/cpuTb.sv

//--- program.hex
// One RV32I instruction word per line, word address 0 first
// Column: instruction in hex, then its assembly and byte address
00C00093 // 00 addi x1, x0, 12
00500113 // 04 addi x2, x0, 5
FF900193 // 08 addi x3, x0, -7
00208233 // 0C add  x4, x1, x2
403202B3 // 10 sub  x5, x4, x3
0042F333 // 14 and  x6, x5, x4
002363B3 // 18 or   x7, x6, x2
0053C433 // 1C xor  x8, x7, x5
0081A4B3 // 20 slt  x9, x3, x8
00402023 // 24 sw   x4, 0(x0)
00502223 // 28 sw   x5, 4(x0)
00602423 // 2C sw   x6, 8(x0)
00702623 // 30 sw   x7, 12(x0)
00802823 // 34 sw   x8, 16(x0)
00902A23 // 38 sw   x9, 20(x0)
00402583 // 3C lw   x11, 4(x0)
06458613 // 40 addi x12, x11, 100
00C02C23 // 44 sw   x12, 24(x0)
01002683 // 48 lw   x13, 16(x0)
00168733 // 4C add  x14, x13, x1
00E02E23 // 50 sw   x14, 28(x0)
00000793 // 54 addi x15, x0, 0
00300813 // 58 addi x16, x0, 3
04000893 // 5C addi x17, x0, 64
00178793 // 60 addi x15, x15, 1
00F8A023 // 64 sw   x15, 0(x17)
00488893 // 68 addi x17, x17, 4
FF079AE3 // 6C bne  x15, x16, 0x60
08F02023 // 70 sw   x15, 128(x0)
00078463 // 74 beq  x15, x0, 0x7C
09102223 // 78 sw   x17, 132(x0)
0080096F // 7C jal  x18, 0x84
08102423 // 80 sw   x1, 136(x0)
09202623 // 84 sw   x18, 140(x0)
4D200993 // 88 addi x19, x0, 1234
0F302E23 // 8C sw   x19, 252(x0)
0000006F // 90 jal  x0, 0x90

//--- tb/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*;
();

  localparam int    maxCycles  = 2000;
  localparam word_t markerAddr = 32'h0000_00FC;
  localparam word_t poisonAddr = 32'h0000_0088;

  logic  clock;
  logic  reset;
  logic  memWriteEnable;
  word_t memAddr;
  word_t writeData;

  // Expected stores in program order
  word_t expAddr [$];
  word_t expData [$];
  int    groupOf [$];
  int    groupLast [$];
  int    groupFails [$];
  string groupName [$];

  int    storeCount = 0;
  int    passCount = 0;
  int    failCount = 0;
  int    cycles;
  word_t lastAddr = '0;
  logic  markerSeen = 1'b0;

  cpuTop dut (
    .clock(clock), .reset(reset), .memWriteEnable(memWriteEnable),
    .memAddr(memAddr), .writeData(writeData)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic expectStore(input word_t addr, input word_t data, input int group);
    begin
      expAddr.push_back(addr);
      expData.push_back(data);
      groupOf.push_back(group);
    end
  endtask

  task automatic loadExpected();
    begin
      groupName.push_back("Arithmetic and forwarding");
      groupName.push_back("Load-use stall");
      groupName.push_back("Branch loop");
      groupName.push_back("Jump and link");
      groupName.push_back("Final marker");
      // x1 = 12, x2 = 5, x3 = -7
      expectStore(32'h00, 32'd17, 0);
      expectStore(32'h04, 32'd24, 0);
      expectStore(32'h08, 32'd16, 0);
      expectStore(32'h0C, 32'd21, 0);
      expectStore(32'h10, 32'd13, 0);
      expectStore(32'h14, 32'd1, 0);
      // Reloaded 24 plus 100, reloaded 13 plus 12
      expectStore(32'h18, 32'd124, 1);
      expectStore(32'h1C, 32'd25, 1);
      // Loop counts then the fall-through stores
      expectStore(32'h40, 32'd1, 2);
      expectStore(32'h44, 32'd2, 2);
      expectStore(32'h48, 32'd3, 2);
      expectStore(32'h80, 32'd3, 2);
      expectStore(32'h84, 32'd76, 2);
      // Link register of the jal at 0x7C
      expectStore(32'h8C, 32'h80, 3);
      expectStore(markerAddr, 32'd1234, 4);
      for (int g = 0; g < groupName.size(); g++)
      begin
        groupLast.push_back(-1);
        groupFails.push_back(0);
      end
      for (int i = 0; i < expAddr.size(); i++)
        groupLast[groupOf[i]] = i;
    end
  endtask

  task automatic reportGroup(input int g);
    begin
      if (groupFails[g] == 0)
        $display("%s: pass", groupName[g]);
      else
        $display("%s: %0d mismatches", groupName[g], groupFails[g]);
    end
  endtask

  task automatic checkStore(input word_t addr, input word_t data);
    int g;
    begin
      assert (addr != poisonAddr)
      begin
        passCount++;
      end
      else
      begin
        failCount++;
        $display("The store after jal was executed at time %0t", $time);
      end
      if (storeCount >= expAddr.size())
      begin
        failCount++;
        $display("Unexpected extra store at time %0t to address %h", $time, addr);
      end
      else
      begin
        g = groupOf[storeCount];
        assert (addr == expAddr[storeCount] && data == expData[storeCount])
        begin
          passCount++;
        end
        else
        begin
          failCount++;
          groupFails[g]++;
          $display("Fail at time %0t: store %0d expected [%h] = %h, observed [%h] = %h",
                   $time, storeCount, expAddr[storeCount], expData[storeCount], addr, data);
        end
        if (storeCount == groupLast[g])
          reportGroup(g);
      end
      if (addr == markerAddr)
        markerSeen = 1'b1;
      lastAddr = addr;
      storeCount++;
    end
  endtask

  task automatic checkCompletion();
    begin
      assert (storeCount == expAddr.size() && lastAddr == markerAddr)
      begin
        passCount++;
        $display("Store order and count: pass, %0d stores", storeCount);
      end
      else
      begin
        failCount++;
        $display("Fail at time %0t: expected %0d stores ending at %h, observed %0d ending at %h",
                 $time, expAddr.size(), markerAddr, storeCount, lastAddr);
      end
    end
  endtask

  // Store port is stable mid-cycle
  always @(negedge clock)
  begin
    if (reset === 1'b1 && memWriteEnable === 1'b1)
      checkStore(memAddr, writeData);
  end

  initial
  begin
    reset = 1'b0;
    loadExpected();

    repeat (16) @(posedge clock);
    reset <= 1'b1;

    cycles = 0;
    while (!markerSeen && cycles < maxCycles)
    begin
      @(posedge clock);
      cycles++;
    end
    if (!markerSeen)
    begin
      failCount++;
      $display("Timeout: the program never finished, no marker store in %0d cycles", maxCycles);
    end

    // The final spin must not store again
    repeat (10) @(posedge clock);
    checkCompletion();

    if (dut.checks.violations != 0)
    begin
      failCount += dut.checks.violations;
      $display("Bound store-port properties failed %0d times", dut.checks.violations);
    end

    $display("Checks passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/cpuTop_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTopProperties import cpuPkg::*;
(
  input logic  clock,
  input logic  reset,
  input logic  memWriteEnable,
  input word_t memAddr,
  input word_t writeData
);

  // Count of failed assertions
  int violations = 0;

  property storeLowInReset;
    @(posedge clock) !reset |-> !memWriteEnable;
  endproperty

  property storeAligned;
    @(posedge clock) disable iff (!reset)
      memWriteEnable |-> (memAddr[1:0] == 2'b00);
  endproperty

  // Data RAM covers dmemWords words from address 0
  property storeInRange;
    @(posedge clock) disable iff (!reset)
      memWriteEnable |-> (memAddr < word_t'(dmemWords * 4));
  endproperty

  property storeKnown;
    @(posedge clock) disable iff (!reset)
      !$isunknown(memWriteEnable) && !$isunknown(writeData);
  endproperty

  assert property (storeLowInReset)
  else
  begin
    violations++;
    $error("store enable high while reset is asserted");
  end

  assert property (storeAligned)
  else
  begin
    violations++;
    $error("store address %h is not word aligned", memAddr);
  end

  assert property (storeInRange)
  else
  begin
    violations++;
    $error("store address %h is beyond the data RAM", memAddr);
  end

  assert property (storeKnown)
  else
  begin
    violations++;
    $error("store enable or store data is unknown");
  end

endmodule

bind cpuTop cpuTopProperties checks (
  .clock(clock), .reset(reset), .memWriteEnable(memWriteEnable),
  .memAddr(memAddr), .writeData(writeData)
);

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*;
(
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero,
  output logic   less
);

  word_t diff;
  logic  overflow;

  assign diff     = a - b;
  assign overflow = (a[31] != b[31]) && (diff[31] != a[31]);

  // Flags for branch decisions
  assign zero = (diff == '0);
  assign less = diff[31] ^ overflow;

  always_comb
  begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = diff;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      aluSlt:  result = {31'b0, less};
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/controlMain.sv
`timescale 1ns/1ps
`default_nettype none

module controlMain import cpuPkg::*;
(
  input  word_t  instr,
  output aluOp_t aluOp,
  output logic   aluSrc,
  output logic   regWrite,
  output logic   memRead,
  output logic   memWrite,
  output logic   memToReg,
  output logic   branch,
  output logic   jump,
  output word_t  imm
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  word_t      immI, immS, immB, immJ;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  // Immediate formats sign-extended from bit 31
  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb
  begin
    // Anything not matched below is a no-op
    aluOp    = aluAdd;
    aluSrc   = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    imm      = '0;
    case (opcode)
      opR:
      begin
        regWrite = 1'b1;
        case (funct3)
          f3AddSub: aluOp = funct7b5 ? aluSub : aluAdd;
          f3Slt:    aluOp = aluSlt;
          f3Xor:    aluOp = aluXor;
          f3Or:     aluOp = aluOr;
          f3And:    aluOp = aluAnd;
          default:  regWrite = 1'b0;
        endcase
      end
      opImm:
      begin
        // Only addi is supported
        regWrite = (funct3 == f3AddSub);
        aluSrc   = 1'b1;
        imm      = immI;
      end
      opLoad:
      begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        memToReg = 1'b1;
        imm      = immI;
      end
      opStore:
      begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        imm      = immS;
      end
      opBranch:
      begin
        // Compare by subtraction for the flags used in MEM
        aluOp  = aluSub;
        branch = 1'b1;
        imm    = immB;
      end
      opJal:
      begin
        jump     = 1'b1;
        regWrite = 1'b1;
        imm      = immJ;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // Common widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [6:0]  opcode_t;

  // Major opcodes of the supported RV32I subset
  localparam opcode_t opR      = 7'b0110011;
  localparam opcode_t opImm    = 7'b0010011;
  localparam opcode_t opLoad   = 7'b0000011;
  localparam opcode_t opStore  = 7'b0100011;
  localparam opcode_t opBranch = 7'b1100011;
  localparam opcode_t opJal    = 7'b1101111;

  // funct3 codes for ALU operations
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // funct3 codes for branches
  localparam logic [2:0] f3Beq = 3'b000;
  localparam logic [2:0] f3Bne = 3'b001;
  localparam logic [2:0] f3Blt = 3'b100;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOp_t;

  // Operand source seen by EX
  typedef enum logic [1:0] {fwdReg, fwdWb, fwdMem} fwdSel_t;

  // Memory sizes in words
  localparam int imemWords = 256;
  localparam int dmemWords = 256;

  localparam word_t resetPc = 32'h0000_0000;

endpackage

`default_nettype wire

//--- verilog/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*;
(
  input  logic  clock,
  input  logic  reset,
  output logic  memWriteEnable,
  output word_t memAddr,
  output word_t writeData
);

  word_t pc, instr, memRdata;

  pipelineCore core (
    .clock(clock), .reset(reset), .pc(pc), .instr(instr),
    .memWrite(memWriteEnable), .memAddr(memAddr), .memWdata(writeData),
    .memRdata(memRdata)
  );

  instrMem imem (.pc(pc), .instr(instr));

  // Store port is shared with the top outputs
  dataMem dmem (
    .clock(clock), .memWrite(memWriteEnable), .memAddr(memAddr),
    .memWdata(writeData), .memRdata(memRdata)
  );

endmodule

`default_nettype wire

//--- verilog/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem import cpuPkg::*;
(
  input  logic  clock,
  input  logic  memWrite,
  input  word_t memAddr,
  input  word_t memWdata,
  output word_t memRdata
);

  word_t ram [dmemWords];
  logic [$clog2(dmemWords)-1:0] index;

  initial
  begin
    for (int i = 0; i < dmemWords; i++)
      ram[i] = '0;
  end

  assign index = memAddr[$clog2(dmemWords)+1:2];

  always_ff @(posedge clock)
  begin
    if (memWrite)
      ram[index] <= memWdata;
  end

  // Loads see the array without a clock
  assign memRdata = ram[index];

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*;
(
  input  regIdx_t idRs1,
  input  regIdx_t idRs2,
  input  regIdx_t exRs1,
  input  regIdx_t exRs2,
  input  regIdx_t exRd,
  input  regIdx_t memRd,
  input  regIdx_t wbRd,
  input  logic    exMemRead,
  input  logic    memRegWrite,
  input  logic    wbRegWrite,
  input  logic    branchTaken,
  input  logic    jump,
  output logic    stall,
  output logic    flushIfId,
  output logic    flushIdEx,
  output logic    flushExMem,
  output fwdSel_t fwdA,
  output fwdSel_t fwdB
);

  logic loadUse;

  // MEM holds the younger result, so it wins over WB
  assign fwdA = (memRegWrite && memRd != '0 && memRd == exRs1) ? fwdMem :
                (wbRegWrite && wbRd != '0 && wbRd == exRs1) ? fwdWb : fwdReg;
  assign fwdB = (memRegWrite && memRd != '0 && memRd == exRs2) ? fwdMem :
                (wbRegWrite && wbRd != '0 && wbRd == exRs2) ? fwdWb : fwdReg;

  // Load in EX feeding the instruction in ID
  assign loadUse = exMemRead && exRd != '0 && (exRd == idRs1 || exRd == idRs2);

  // A taken branch squashes the stalled instruction anyway
  assign stall = loadUse && !branchTaken;

  // A stalled jal waits and redirects one cycle later
  assign flushIfId  = branchTaken || (jump && !loadUse);
  assign flushIdEx  = branchTaken || loadUse;
  assign flushExMem = branchTaken;

endmodule

`default_nettype wire

//--- verilog/instrMem.sv
`timescale 1ns/1ps
`default_nettype none

module instrMem import cpuPkg::*;
(
  input  word_t pc,
  output word_t instr
);

  word_t rom [imemWords];

  initial
  begin
    for (int i = 0; i < imemWords; i++)
      rom[i] = '0;
    $readmemh("program.hex", rom);
  end

  // Word index with the byte offset dropped
  assign instr = rom[pc[$clog2(imemWords)+1:2]];

endmodule

`default_nettype wire

//--- verilog/pipelineCore.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineCore import cpuPkg::*;
(
  input  logic  clock,
  input  logic  reset,
  output word_t pc,
  input  word_t instr,
  output logic  memWrite,
  output word_t memAddr,
  output word_t memWdata,
  input  word_t memRdata
);

  // IF/ID
  word_t ifIdPc, ifIdInstr;

  // ID stage
  regIdx_t idRs1, idRs2, idRd;
  word_t   idRs1Data, idRs2Data, idImm, jalTarget, nextPc;
  aluOp_t  idAluOp;
  logic    idAluSrc, idRegWrite, idMemRead, idMemWrite, idMemToReg, idBranch, idJump;

  // ID/EX
  word_t   idExPc, idExRs1Data, idExRs2Data, idExImm;
  regIdx_t idExRs1, idExRs2, idExRd;
  logic [2:0] idExFunct3;
  aluOp_t  idExAluOp;
  logic    idExAluSrc, idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg;
  logic    idExBranch, idExJump;

  // EX stage
  fwdSel_t fwdA, fwdB;
  word_t   opA, opB, aluB, aluResult, exResult;
  logic    aluZero, aluLess;

  // EX/MEM
  word_t   exMemResult, exMemStoreData, exMemTarget;
  regIdx_t exMemRd;
  logic [2:0] exMemFunct3;
  logic    exMemRegWrite, exMemMemWrite, exMemMemToReg, exMemBranch, exMemZero, exMemLess;
  logic    branchCond, branchTaken;

  // MEM/WB
  word_t   memWbResult, memWbLoad, wbData;
  regIdx_t memWbRd;
  logic    memWbRegWrite, memWbMemToReg;

  logic stall, flushIfId, flushIdEx, flushExMem;

  // Branch in MEM beats jal in ID
  assign jalTarget = ifIdPc + idImm;
  assign nextPc = branchTaken ? exMemTarget : idJump ? jalTarget : pc + 32'd4;

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
      pc <= resetPc;
    else if (!stall)
      pc <= nextPc;
  end

  // A cleared instruction word decodes as a no-op
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
      ifIdInstr <= '0;
    else if (flushIfId)
      ifIdInstr <= '0;
    else if (!stall)
      ifIdInstr <= instr;
  end

  always_ff @(posedge clock)
  begin
    if (!stall)
      ifIdPc <= pc;
  end

  // Decode
  assign idRs1 = ifIdInstr[19:15];
  assign idRs2 = ifIdInstr[24:20];
  assign idRd  = ifIdInstr[11:7];

  controlMain decoder (
    .instr(ifIdInstr), .aluOp(idAluOp), .aluSrc(idAluSrc), .regWrite(idRegWrite),
    .memRead(idMemRead), .memWrite(idMemWrite), .memToReg(idMemToReg),
    .branch(idBranch), .jump(idJump), .imm(idImm)
  );

  regFile regs (
    .clock(clock), .reset(reset), .rs1(idRs1), .rs2(idRs2), .rd(memWbRd),
    .writeEnable(memWbRegWrite), .writeData(wbData), .rdata1(idRs1Data), .rdata2(idRs2Data)
  );

  hazardUnit hazards (
    .idRs1(idRs1), .idRs2(idRs2), .exRs1(idExRs1), .exRs2(idExRs2), .exRd(idExRd),
    .memRd(exMemRd), .wbRd(memWbRd), .exMemRead(idExMemRead),
    .memRegWrite(exMemRegWrite), .wbRegWrite(memWbRegWrite),
    .branchTaken(branchTaken), .jump(idJump), .stall(stall), .flushIfId(flushIfId),
    .flushIdEx(flushIdEx), .flushExMem(flushExMem), .fwdA(fwdA), .fwdB(fwdB)
  );

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      idExRegWrite <= 1'b0;
      idExMemRead  <= 1'b0;
      idExMemWrite <= 1'b0;
      idExMemToReg <= 1'b0;
      idExBranch   <= 1'b0;
      idExJump     <= 1'b0;
    end
    else
    begin
      idExRegWrite <= idRegWrite && !flushIdEx;
      idExMemRead  <= idMemRead && !flushIdEx;
      idExMemWrite <= idMemWrite && !flushIdEx;
      idExMemToReg <= idMemToReg && !flushIdEx;
      idExBranch   <= idBranch && !flushIdEx;
      idExJump     <= idJump && !flushIdEx;
    end
  end

  always_ff @(posedge clock)
  begin
    idExPc      <= ifIdPc;
    idExRs1Data <= idRs1Data;
    idExRs2Data <= idRs2Data;
    idExImm     <= idImm;
    idExRs1     <= idRs1;
    idExRs2     <= idRs2;
    idExRd      <= idRd;
    idExFunct3  <= ifIdInstr[14:12];
    idExAluOp   <= idAluOp;
    idExAluSrc  <= idAluSrc;
  end

  // Execute with forwarded operands
  assign opA = (fwdA == fwdMem) ? exMemResult : (fwdA == fwdWb) ? wbData : idExRs1Data;
  assign opB = (fwdB == fwdMem) ? exMemResult : (fwdB == fwdWb) ? wbData : idExRs2Data;
  assign aluB = idExAluSrc ? idExImm : opB;

  alu execAlu (
    .a(opA), .b(aluB), .op(idExAluOp), .result(aluResult), .zero(aluZero), .less(aluLess)
  );

  // jal writes its link address
  assign exResult = idExJump ? idExPc + 32'd4 : aluResult;

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      exMemRegWrite <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemMemToReg <= 1'b0;
      exMemBranch   <= 1'b0;
    end
    else
    begin
      exMemRegWrite <= idExRegWrite && !flushExMem;
      exMemMemWrite <= idExMemWrite && !flushExMem;
      exMemMemToReg <= idExMemToReg && !flushExMem;
      exMemBranch   <= idExBranch && !flushExMem;
    end
  end

  always_ff @(posedge clock)
  begin
    exMemResult    <= exResult;
    exMemStoreData <= opB;
    exMemTarget    <= idExPc + idExImm;
    exMemRd        <= idExRd;
    exMemFunct3    <= idExFunct3;
    exMemZero      <= aluZero;
    exMemLess      <= aluLess;
  end

  // Branch decision in MEM
  always_comb
  begin
    case (exMemFunct3)
      f3Beq:   branchCond = exMemZero;
      f3Bne:   branchCond = !exMemZero;
      f3Blt:   branchCond = exMemLess;
      default: branchCond = 1'b0;
    endcase
  end

  assign branchTaken = exMemBranch && branchCond;

  assign memWrite = exMemMemWrite;
  assign memAddr  = exMemResult;
  assign memWdata = exMemStoreData;

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      memWbRegWrite <= 1'b0;
      memWbMemToReg <= 1'b0;
    end
    else
    begin
      memWbRegWrite <= exMemRegWrite;
      memWbMemToReg <= exMemMemToReg;
    end
  end

  always_ff @(posedge clock)
  begin
    memWbResult <= exMemResult;
    memWbLoad   <= memRdata;
    memWbRd     <= exMemRd;
  end

  // Writeback select
  assign wbData = memWbMemToReg ? memWbLoad : memWbResult;

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  regIdx_t rs1,
  input  regIdx_t rs2,
  input  regIdx_t rd,
  input  logic    writeEnable,
  input  word_t   writeData,
  output word_t   rdata1,
  output word_t   rdata2
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (writeEnable && rd != '0)
      regs[rd] <= writeData;
  end

  // WB write bypasses to the ID read in the same cycle
  assign rdata1 = (rs1 == '0) ? '0 : (writeEnable && rd == rs1) ? writeData : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : (writeEnable && rd == rs2) ? writeData : regs[rs2];

endmodule

`default_nettype wire
